// File: logic/dma_mem_pkg.sv
package dma_mem_pkg;

   // Block address as carried in a DMA packet
   localparam int addr_width = 12;

   // One fill beat, also one memory word
   localparam int fill_width = 32;

   localparam int block_beats = 4;
   localparam int beat_sel_width = 2;

   // Low block address bits folded with the bits just above them
   localparam int hash_bits = 2;

   typedef enum logic
   {
      e_dma_read  = 1'b0,
      e_dma_write = 1'b1
   } dma_opcode_e;

   typedef struct packed
   {
      dma_opcode_e opcode;
      logic [addr_width-1:0] addr;
   } dma_pkt_t;

endpackage

// File: logic/dma_ifs.sv
`timescale 1ns/1ps

interface dma_req_if
  #(parameter int num_ports_p = 2);

   localparam int port_width_lp = (num_ports_p > 1) ? $clog2(num_ports_p) : 1;

   logic v;
   dma_mem_pkg::dma_pkt_t pkt;
   logic [port_width_lp-1:0] port;
   logic take;

   modport source (output v, output pkt, output port, input take);
   modport sink (input v, input pkt, input port, output take);

endinterface

interface mem_port_if;

   logic en;
   logic we;
   logic [dma_mem_pkg::addr_width+dma_mem_pkg::beat_sel_width-1:0] addr;
   logic [dma_mem_pkg::fill_width-1:0] wdata;
   logic [dma_mem_pkg::fill_width-1:0] rdata;

   modport engine (output en, output we, output addr, output wdata, input rdata);
   modport memory (input en, input we, input addr, input wdata, output rdata);

endinterface

// File: logic/dma_port_arbiter.sv
`timescale 1ns/1ps

module dma_port_arbiter
  #(parameter int num_ports_p = 2)
   (
   input  logic                                    clk_i,
   input  logic                                    rst_n_i,

   input  dma_mem_pkg::dma_pkt_t [num_ports_p-1:0] dma_pkt_i,
   input  logic [num_ports_p-1:0]                  dma_pkt_v_i,
   output logic [num_ports_p-1:0]                  dma_pkt_yumi_o,

   dma_req_if.source                               req_io
   );

   localparam int port_width_lp = (num_ports_p > 1) ? $clog2(num_ports_p) : 1;

   logic [port_width_lp-1:0] ptr_r;
   logic [port_width_lp-1:0] grant;
   logic found;

   // First valid port at or after the pointer, wrapping around
   always_comb
   begin
      int idx;
      found = 1'b0;
      grant = ptr_r;
      for (int off = 0; off < num_ports_p; off++)
      begin
         idx = (int'(ptr_r) + off) % num_ports_p;
         if (!found && dma_pkt_v_i[idx])
         begin
            found = 1'b1;
            grant = port_width_lp'(idx);
         end
      end
   end

   assign req_io.v = found;
   assign req_io.pkt = dma_pkt_i[grant];
   assign req_io.port = grant;

   always_comb
   begin
      dma_pkt_yumi_o = '0;
      if (found && req_io.take)
      begin
         dma_pkt_yumi_o[grant] = 1'b1;
      end
   end

   // Granted port drops to lowest priority
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         ptr_r <= '0;
      end
      else if (found && req_io.take)
      begin
         ptr_r <= port_width_lp'((int'(grant) + 1) % num_ports_p);
      end
   end

endmodule

// File: logic/dma_block_engine.sv
`timescale 1ns/1ps

module dma_block_engine
  #(parameter int num_ports_p = 2)
   (
   input  logic                                                  clk_i,
   input  logic                                                  rst_n_i,

   dma_req_if.sink                                               req_io,
   mem_port_if.engine                                            mem_io,

   output logic [num_ports_p-1:0][dma_mem_pkg::fill_width-1:0]   dma_data_o,
   output logic [num_ports_p-1:0]                                dma_data_v_o,
   input  logic [num_ports_p-1:0]                                dma_data_ready_i,

   input  logic [num_ports_p-1:0][dma_mem_pkg::fill_width-1:0]   dma_data_i,
   input  logic [num_ports_p-1:0]                                dma_data_v_i,
   output logic [num_ports_p-1:0]                                dma_data_yumi_o
   );

   localparam int port_width_lp = (num_ports_p > 1) ? $clog2(num_ports_p) : 1;
   localparam int hb_lp = dma_mem_pkg::hash_bits;

   typedef enum logic [1:0]
   {
      e_idle,
      e_write_beat,
      e_read_issue,
      e_read_hold
   } state_e;

   state_e state_r;

   logic [port_width_lp-1:0] port_r;
   logic [dma_mem_pkg::addr_width-1:0] block_r;
   logic [dma_mem_pkg::beat_sel_width-1:0] beat_r;

   logic [dma_mem_pkg::addr_width-1:0] hashed_addr;
   logic [dma_mem_pkg::addr_width-1:0] phys_block;
   logic accept;
   logic beat_done;
   logic last_beat;

   // Undo the bank hash on the incoming block address
   assign hashed_addr = req_io.pkt.addr;

   always_comb
   begin
      phys_block = hashed_addr;
      phys_block[hb_lp-1:0] = hashed_addr[hb_lp-1:0] ^ hashed_addr[2*hb_lp-1:hb_lp];
   end

   assign accept = (state_r == e_idle) && req_io.v;
   assign last_beat = (beat_r == dma_mem_pkg::beat_sel_width'(dma_mem_pkg::block_beats - 1));

   always_comb
   begin
      req_io.take = (state_r == e_idle);
      mem_io.en = 1'b0;
      mem_io.we = 1'b0;
      mem_io.addr = {block_r, beat_r};
      mem_io.wdata = dma_data_i[port_r];
      dma_data_yumi_o = '0;
      dma_data_v_o = '0;
      beat_done = 1'b0;
      case (state_r)
         e_write_beat:
         begin
            // Each beat goes to memory in the cycle it is taken
            dma_data_yumi_o[port_r] = dma_data_v_i[port_r];
            mem_io.en = dma_data_v_i[port_r];
            mem_io.we = 1'b1;
            beat_done = dma_data_v_i[port_r];
         end
         e_read_issue:
         begin
            mem_io.en = 1'b1;
         end
         e_read_hold:
         begin
            // Memory output register holds the word while stalled
            dma_data_v_o[port_r] = 1'b1;
            beat_done = dma_data_ready_i[port_r];
         end
         default:
         begin
         end
      endcase
   end

   // Shared read data bus
   always_comb
   begin
      for (int i = 0; i < num_ports_p; i++)
      begin
         dma_data_o[i] = mem_io.rdata;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         state_r <= e_idle;
         beat_r <= '0;
      end
      else
      begin
         case (state_r)
            e_idle:
            begin
               if (accept)
               begin
                  beat_r <= '0;
                  if (req_io.pkt.opcode == dma_mem_pkg::e_dma_write)
                  begin
                     state_r <= e_write_beat;
                  end
                  else
                  begin
                     state_r <= e_read_issue;
                  end
               end
            end
            e_write_beat:
            begin
               if (beat_done)
               begin
                  beat_r <= beat_r + 1'b1;
                  if (last_beat)
                  begin
                     state_r <= e_idle;
                  end
               end
            end
            e_read_issue:
            begin
               state_r <= e_read_hold;
            end
            e_read_hold:
            begin
               if (beat_done)
               begin
                  beat_r <= beat_r + 1'b1;
                  state_r <= last_beat ? e_idle : e_read_issue;
               end
            end
            default:
            begin
               state_r <= e_idle;
            end
         endcase
      end
   end

   // Owner and physical block of the current transfer
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         port_r <= req_io.port;
         block_r <= phys_block;
      end
   end

endmodule

// File: logic/dma_mem_array.sv
`timescale 1ns/1ps

module dma_mem_array
  #(parameter int mem_words_p = 16384)
   (
   input  logic        clk_i,
   mem_port_if.memory  mem_io
   );

   logic [dma_mem_pkg::fill_width-1:0] mem_r [mem_words_p];
   logic [dma_mem_pkg::fill_width-1:0] rdata_r;

   // Each word starts out holding its own index
   initial
   begin
      for (int i = 0; i < mem_words_p; i++)
      begin
         mem_r[i] = dma_mem_pkg::fill_width'(i);
      end
   end

   always @(posedge clk_i)
   begin
      if (mem_io.en && mem_io.we)
      begin
         mem_r[mem_io.addr] <= mem_io.wdata;
      end
   end

   // Registered read, kept until the next read
   always_ff @(posedge clk_i)
   begin
      if (mem_io.en && !mem_io.we)
      begin
         rdata_r <= mem_r[mem_io.addr];
      end
   end

   assign mem_io.rdata = rdata_r;

endmodule

// File: logic/dma_mem_subsystem.sv
`timescale 1ns/1ps

module dma_mem_subsystem
  #(parameter int num_ports_p = 2,
    parameter int mem_words_p = 16384)
   (
   input  logic                                                  clk_i,
   input  logic                                                  rst_n_i,

   input  logic [num_ports_p-1:0][$bits(dma_mem_pkg::dma_pkt_t)-1:0] dma_pkt_i,
   input  logic [num_ports_p-1:0]                                dma_pkt_v_i,
   output logic [num_ports_p-1:0]                                dma_pkt_yumi_o,

   output logic [num_ports_p-1:0][dma_mem_pkg::fill_width-1:0]   dma_data_o,
   output logic [num_ports_p-1:0]                                dma_data_v_o,
   input  logic [num_ports_p-1:0]                                dma_data_ready_i,

   input  logic [num_ports_p-1:0][dma_mem_pkg::fill_width-1:0]   dma_data_i,
   input  logic [num_ports_p-1:0]                                dma_data_v_i,
   output logic [num_ports_p-1:0]                                dma_data_yumi_o
   );

   dma_req_if #(.num_ports_p(num_ports_p)) req_if ();
   mem_port_if mem_if ();

   dma_port_arbiter
     #(.num_ports_p(num_ports_p))
   i_dma_port_arbiter
     (.clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .dma_pkt_i      (dma_pkt_i),
      .dma_pkt_v_i    (dma_pkt_v_i),
      .dma_pkt_yumi_o (dma_pkt_yumi_o),
      .req_io         (req_if)
      );

   dma_block_engine
     #(.num_ports_p(num_ports_p))
   i_dma_block_engine
     (.clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .req_io           (req_if),
      .mem_io           (mem_if),
      .dma_data_o       (dma_data_o),
      .dma_data_v_o     (dma_data_v_o),
      .dma_data_ready_i (dma_data_ready_i),
      .dma_data_i       (dma_data_i),
      .dma_data_v_i     (dma_data_v_i),
      .dma_data_yumi_o  (dma_data_yumi_o)
      );

   dma_mem_array
     #(.mem_words_p(mem_words_p))
   i_dma_mem_array
     (.clk_i  (clk_i),
      .mem_io (mem_if)
      );

endmodule

// File: sim/dma_mem_sva.sv
`timescale 1ns/1ps

module dma_mem_sva
  #(parameter int num_ports_p = 2)
   (
   input logic                                                clk_i,
   input logic                                                rst_n_i,
   input logic [num_ports_p-1:0]                              dma_pkt_v_i,
   input logic [num_ports_p-1:0]                              dma_pkt_yumi_o,
   input logic [num_ports_p-1:0][dma_mem_pkg::fill_width-1:0] dma_data_o,
   input logic [num_ports_p-1:0]                              dma_data_v_o,
   input logic [num_ports_p-1:0]                              dma_data_ready_i,
   input logic [num_ports_p-1:0]                              dma_data_v_i,
   input logic [num_ports_p-1:0]                              dma_data_yumi_o
   );

   // Yumi only for an offered packet or beat
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (dma_pkt_yumi_o & ~dma_pkt_v_i) == '0)
   else $error("packet yumi raised without packet valid");

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (dma_data_yumi_o & ~dma_data_v_i) == '0)
   else $error("write data yumi raised without write data valid");

   // Shared read bus serves one port at a time
   assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(dma_data_v_o))
   else $error("read data valid raised on more than one port");

   for (genvar p = 0; p < num_ports_p; p++)
   begin : g_hold
      assert property (@(posedge clk_i) disable iff (!rst_n_i)
         dma_data_v_o[p] && !dma_data_ready_i[p] |=> dma_data_v_o[p] && $stable(dma_data_o[p]))
      else $error("read beat on port %0d changed while stalled", p);
   end

endmodule

bind dma_mem_subsystem dma_mem_sva
  #(.num_ports_p(num_ports_p))
i_dma_mem_sva
  (.clk_i            (clk_i),
   .rst_n_i          (rst_n_i),
   .dma_pkt_v_i      (dma_pkt_v_i),
   .dma_pkt_yumi_o   (dma_pkt_yumi_o),
   .dma_data_o       (dma_data_o),
   .dma_data_v_o     (dma_data_v_o),
   .dma_data_ready_i (dma_data_ready_i),
   .dma_data_v_i     (dma_data_v_i),
   .dma_data_yumi_o  (dma_data_yumi_o)
   );

// File: sim/dma_mem_tb.sv
`timescale 1ns/1ps

module dma_mem_tb;

   localparam int num_ports_lp = 2;
   localparam int mem_words_lp = 16384;
   localparam int clk_period_lp = 40;
   localparam int beats_lp = dma_mem_pkg::block_beats;
   localparam int hb_lp = dma_mem_pkg::hash_bits;
   localparam int rand_pkts_lp = 100;
   // Directed tests issue 40 packets in all
   localparam int total_pkts_lp = 40 + num_ports_lp * rand_pkts_lp;
   localparam int timeout_ns_lp = total_pkts_lp * 40 * clk_period_lp;

   logic clk_i;
   logic rst_n_i;
   dma_mem_pkg::dma_pkt_t [num_ports_lp-1:0] dma_pkt_i;
   logic [num_ports_lp-1:0] dma_pkt_v_i;
   logic [num_ports_lp-1:0] dma_pkt_yumi_o;
   logic [num_ports_lp-1:0][dma_mem_pkg::fill_width-1:0] dma_data_o;
   logic [num_ports_lp-1:0] dma_data_v_o;
   logic [num_ports_lp-1:0] dma_data_ready_i;
   logic [num_ports_lp-1:0][dma_mem_pkg::fill_width-1:0] dma_data_i;
   logic [num_ports_lp-1:0] dma_data_v_i;
   logic [num_ports_lp-1:0] dma_data_yumi_o;

   dma_mem_pkg::dma_pkt_t pkt_q [num_ports_lp][$];
   logic [dma_mem_pkg::fill_width-1:0] model_mem [mem_words_lp];
   logic [dma_mem_pkg::fill_width-1:0] held;
   bit throttle_en;
   bit gap_en;
   bit alt_check;
   bit active;
   bit is_write;
   bit stalled;
   int owner;
   int phys;
   int beat;
   int ptr_m;
   int last_grant;
   int taken_cnt;
   int beat_cnt;
   int errors;
   int tests_run;
   int tests_failed;

   dma_mem_subsystem
     #(.num_ports_p(num_ports_lp),
       .mem_words_p(mem_words_lp))
   i_dma_mem_subsystem
     (.clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .dma_pkt_i        (dma_pkt_i),
      .dma_pkt_v_i      (dma_pkt_v_i),
      .dma_pkt_yumi_o   (dma_pkt_yumi_o),
      .dma_data_o       (dma_data_o),
      .dma_data_v_o     (dma_data_v_o),
      .dma_data_ready_i (dma_data_ready_i),
      .dma_data_i       (dma_data_i),
      .dma_data_v_i     (dma_data_v_i),
      .dma_data_yumi_o  (dma_data_yumi_o)
      );

   initial
   begin
      clk_i = 1'b0;
      forever
      begin
         #(clk_period_lp / 2);
         clk_i = ~clk_i;
      end
   end

   initial
   begin
      #(timeout_ns_lp);
      $display("Watchdog expired after %0d ns with tests still running", timeout_ns_lp);
      $display("TEST FAILED");
      $finish;
   end

   function automatic void report_error(input string msg);
      $display("%s", msg);
      errors++;
   endfunction

   // Physical block: low hash bits folded with the bits just above
   function automatic int phys_block(input logic [dma_mem_pkg::addr_width-1:0] addr);
      int a;
      a = int'(addr);
      return a ^ ((a >> hb_lp) & ((1 << hb_lp) - 1));
   endfunction

   function automatic dma_mem_pkg::dma_pkt_t make_pkt(input dma_mem_pkg::dma_opcode_e op,
                                                      input int addr);
      dma_mem_pkg::dma_pkt_t pkt;
      pkt.opcode = op;
      pkt.addr = dma_mem_pkg::addr_width'(addr);
      return pkt;
   endfunction

   task automatic next_cycle();
      @(posedge clk_i);
      #2;
   endtask

   // Ready is random on every port while throttled
   initial
   begin
      forever
      begin
         next_cycle();
         dma_data_ready_i = throttle_en ? num_ports_lp'($urandom) : '1;
      end
   end

   task automatic run_port(input int p);
      dma_mem_pkg::dma_pkt_t pkt;
      int beats;
      bit taken;
      bit moved;
      while (pkt_q[p].size() > 0)
      begin
         pkt = pkt_q[p].pop_front();
         if (gap_en)
         begin
            repeat ($urandom_range(0, 3)) next_cycle();
         end
         dma_pkt_i[p] = pkt;
         dma_pkt_v_i[p] = 1'b1;
         taken = 1'b0;
         // Stray write beats while waiting must not be taken
         while (!taken)
         begin
            dma_data_v_i[p] = throttle_en && ($urandom_range(0, 1) == 1);
            dma_data_i[p] = $urandom;
            @(negedge clk_i);
            taken = dma_pkt_yumi_o[p];
            next_cycle();
         end
         dma_pkt_v_i[p] = 1'b0;
         dma_data_v_i[p] = 1'b0;
         dma_data_i[p] = $urandom;
         beats = 0;
         while (beats < beats_lp)
         begin
            if (pkt.opcode == dma_mem_pkg::e_dma_write)
            begin
               dma_data_v_i[p] = !throttle_en || ($urandom_range(0, 1) == 1);
            end
            @(negedge clk_i);
            moved = dma_data_yumi_o[p] || (dma_data_v_o[p] && dma_data_ready_i[p]);
            next_cycle();
            if (moved)
            begin
               beats++;
               dma_data_i[p] = $urandom;
            end
         end
         dma_data_v_i[p] = 1'b0;
      end
   endtask

   task automatic run_test(input string name, input int errs_start);
      int pkts;
      pkts = 0;
      for (int p = 0; p < num_ports_lp; p++)
      begin
         pkts += pkt_q[p].size();
      end
      next_cycle();
      fork
         run_port(0);
         run_port(1);
      join
      repeat (3) next_cycle();
      assert (!active) else report_error($sformatf("%s ended with a transfer still open", name));
      assert (taken_cnt == pkts)
      else report_error($sformatf("[ERROR] packets taken: got %h expected %h", taken_cnt, pkts));
      assert (beat_cnt == pkts * beats_lp)
      else report_error($sformatf("[ERROR] beats moved: got %h expected %h",
                                  beat_cnt, pkts * beats_lp));
      tests_run++;
      if (errors == errs_start)
      begin
         $display("%s: passed", name);
      end
      else
      begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - errs_start);
      end
      taken_cnt = 0;
      beat_cnt = 0;
   endtask

   // Reference model, sampled where outputs are settled
   always @(negedge clk_i)
   begin
      logic [num_ports_lp-1:0] exp_yumi;
      logic [num_ports_lp-1:0] exp_dyumi;
      logic [num_ports_lp-1:0] read_mask;
      int q;
      int g;
      if (!rst_n_i)
      begin
         active = 1'b0;
         stalled = 1'b0;
         ptr_m = 0;
         last_grant = -1;
      end
      else
      begin
         exp_yumi = '0;
         exp_dyumi = '0;
         read_mask = '0;
         for (int k = 0; k < num_ports_lp && !active; k++)
         begin
            q = (ptr_m + k) % num_ports_lp;
            if (dma_pkt_v_i[q] && exp_yumi == '0)
               exp_yumi[q] = 1'b1;
         end
         if (active && is_write)
            exp_dyumi[owner] = dma_data_v_i[owner];
         if (active && !is_write)
            read_mask[owner] = 1'b1;
         assert (dma_pkt_yumi_o == exp_yumi)
         else report_error($sformatf("[ERROR] dma_pkt_yumi_o: got %h expected %h",
                                     dma_pkt_yumi_o, exp_yumi));
         assert (dma_data_yumi_o == exp_dyumi)
         else report_error($sformatf("[ERROR] dma_data_yumi_o: got %h expected %h",
                                     dma_data_yumi_o, exp_dyumi));
         assert ((dma_data_v_o & ~read_mask) == '0)
         else report_error($sformatf("[ERROR] dma_data_v_o: got %h allowed %h",
                                     dma_data_v_o, read_mask));
         if (active && is_write && dma_data_yumi_o[owner])
         begin
            model_mem[phys * beats_lp + beat] = dma_data_i[owner];
            beat++;
            beat_cnt++;
            active = (beat < beats_lp);
         end
         if (active && !is_write && dma_data_v_o[owner])
         begin
            if (stalled)
            begin
               assert (dma_data_o[owner] == held)
               else report_error($sformatf("[ERROR] dma_data_o[%0d] while stalled: got %h expected %h",
                                           owner, dma_data_o[owner], held));
            end
            if (dma_data_ready_i[owner])
            begin
               assert (dma_data_o[owner] == model_mem[phys * beats_lp + beat])
               else report_error($sformatf("[ERROR] dma_data_o[%0d] beat %0d: got %h expected %h",
                                           owner, beat, dma_data_o[owner],
                                           model_mem[phys * beats_lp + beat]));
               stalled = 1'b0;
               beat++;
               beat_cnt++;
               active = (beat < beats_lp);
            end
            else
            begin
               stalled = 1'b1;
               held = dma_data_o[owner];
            end
         end
         else
         begin
            assert (!stalled) else report_error("read beat withdrawn before the port accepted it");
            stalled = 1'b0;
         end
         if (dma_pkt_yumi_o != '0)
         begin
            g = 0;
            for (int k = 0; k < num_ports_lp; k++)
            begin
               if (dma_pkt_yumi_o[k])
                  g = k;
            end
            if (alt_check && (&dma_pkt_v_i) && last_grant >= 0)
            begin
               assert (g != last_grant)
               else report_error($sformatf("port %0d granted twice in a row with both waiting", g));
            end
            last_grant = g;
            ptr_m = (g + 1) % num_ports_lp;
            owner = g;
            is_write = (dma_pkt_i[g].opcode == dma_mem_pkg::e_dma_write);
            phys = phys_block(dma_pkt_i[g].addr);
            beat = 0;
            active = 1'b1;
            taken_cnt++;
         end
      end
   end

   initial
   begin
      int errs_start;
      dma_mem_pkg::dma_opcode_e op;
      void'($urandom(32'haeaabd02));
      rst_n_i = 1'b0;
      dma_pkt_i = '0;
      dma_pkt_v_i = '0;
      dma_data_i = '0;
      dma_data_v_i = '0;
      dma_data_ready_i = '0;
      for (int i = 0; i < mem_words_lp; i++)
         model_mem[i] = dma_mem_pkg::fill_width'(i);
      repeat (2) @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;

      errs_start = errors;
      @(negedge clk_i);
      assert (dma_pkt_yumi_o == '0)
      else report_error($sformatf("[ERROR] dma_pkt_yumi_o after reset: got %h", dma_pkt_yumi_o));
      assert (dma_data_yumi_o == '0)
      else report_error($sformatf("[ERROR] dma_data_yumi_o after reset: got %h", dma_data_yumi_o));
      assert (dma_data_v_o == '0)
      else report_error($sformatf("[ERROR] dma_data_v_o after reset: got %h", dma_data_v_o));
      run_test("reset_state", errs_start);

      errs_start = errors;
      throttle_en = 1'b1;
      pkt_q[0].push_back(make_pkt(dma_mem_pkg::e_dma_read, 'h000));
      pkt_q[0].push_back(make_pkt(dma_mem_pkg::e_dma_read, 'h00d));
      pkt_q[0].push_back(make_pkt(dma_mem_pkg::e_dma_read, 'h0a6));
      pkt_q[0].push_back(make_pkt(dma_mem_pkg::e_dma_read, 'hfff));
      run_test("unwritten_read", errs_start);

      // 0x02d and 0x02e swap physical blocks under the hash
      errs_start = errors;
      pkt_q[1].push_back(make_pkt(dma_mem_pkg::e_dma_write, 'h02d));
      pkt_q[1].push_back(make_pkt(dma_mem_pkg::e_dma_read, 'h02d));
      pkt_q[1].push_back(make_pkt(dma_mem_pkg::e_dma_read, 'h02e));
      pkt_q[1].push_back(make_pkt(dma_mem_pkg::e_dma_read, 'h02c));
      run_test("write_read_back", errs_start);

      errs_start = errors;
      throttle_en = 1'b0;
      alt_check = 1'b1;
      for (int n = 0; n < 8; n++)
      begin
         pkt_q[0].push_back(make_pkt(dma_mem_pkg::e_dma_read, n));
         pkt_q[1].push_back(make_pkt(dma_mem_pkg::e_dma_read, n + 8));
      end
      run_test("round_robin", errs_start);

      errs_start = errors;
      alt_check = 1'b0;
      throttle_en = 1'b1;
      gap_en = 1'b1;
      for (int p = 0; p < num_ports_lp; p++)
      begin
         for (int n = 0; n < rand_pkts_lp; n++)
         begin
            op = ($urandom_range(0, 1) == 1) ? dma_mem_pkg::e_dma_write : dma_mem_pkg::e_dma_read;
            pkt_q[p].push_back(make_pkt(op, int'($urandom_range(0, 31))));
         end
      end
      run_test("random_traffic", errs_start);

      errs_start = errors;
      gap_en = 1'b0;
      for (int p = 0; p < num_ports_lp; p++)
      begin
         for (int n = 0; n < 6; n++)
            pkt_q[p].push_back(make_pkt(dma_mem_pkg::e_dma_write, 8 + 8 * p + n));
         pkt_q[p].push_back(make_pkt(dma_mem_pkg::e_dma_read, 8 + 8 * p));
         pkt_q[p].push_back(make_pkt(dma_mem_pkg::e_dma_read, 9 + 8 * p));
      end
      run_test("write_beat_ownership", errs_start);

      $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
      begin
         $display("TEST OK");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: project.f
logic/dma_mem_pkg.sv
logic/dma_ifs.sv
logic/dma_port_arbiter.sv
logic/dma_block_engine.sv
logic/dma_mem_array.sv
logic/dma_mem_subsystem.sv
sim/dma_mem_sva.sv
sim/dma_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module dma_mem_tb \
   -f project.f \
   -o dma_mem_sim

./obj_dir/dma_mem_sim +verilator+error+limit+100 | tee sim.log

if grep -qx "TEST OK" sim.log
then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
